// ==== Bender.yml ====
package:
  name: ram_clock_bridge

sources:
  - source/ramBridgePkg.sv
  - source/grayAsyncFifo.sv
  - source/syncFifo.sv
  - source/ramClockBridge.sv
  - source/sramController.sv
  - source/ramSubsystem.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/ramChecker.sv
      - tb/ramSubsystemTb.sv

// ==== flist.f ====
source/ramBridgePkg.sv
source/grayAsyncFifo.sv
source/syncFifo.sv
source/ramClockBridge.sv
source/sramController.sv
source/ramSubsystem.sv
tb/clockGen.sv
tb/ramChecker.sv
tb/ramSubsystemTb.sv

// ==== source/grayAsyncFifo.sv ====
`timescale 1ns/1ns

module grayAsyncFifo #(
	parameter int width = 8,
	parameter int depth = 16
)(
	input logic [width-1:0] wd,
	input logic push,
	output logic full,
	output logic [width-1:0] rd,
	input logic pop,
	output logic empty,
	input logic srcReset,
	input logic dstReset,
	input logic srcClk,
	input logic dstClk
);

	// pointers carry one extra wrap bit over the array index
	logic [$clog2(depth):0] wrBin;
	logic [$clog2(depth):0] wrGray;
	logic [$clog2(depth):0] wrBinNext;
	logic [$clog2(depth):0] rdGraySync1;
	logic [$clog2(depth):0] rdGraySync2;
	logic [$clog2(depth):0] rdBin;
	logic [$clog2(depth):0] rdGray;
	logic [$clog2(depth):0] rdBinNext;
	logic [$clog2(depth):0] wrGraySync1;
	logic [$clog2(depth):0] wrGraySync2;
	logic pushOk;
	logic popOk;

	// storage, written in srcClk and read in dstClk
	logic [width-1:0] mem [depth];

	// pushing into a full FIFO or popping an empty one is dropped
	assign pushOk = push & ~full;
	assign popOk = pop & ~empty;

	assign wrBinNext = wrBin + 1'b1;
	assign rdBinNext = rdBin + 1'b1;

	// --------------------------------------------------
	// source domain
	// --------------------------------------------------

	always_ff @(posedge srcClk)
	begin
		if (srcReset)
		begin
			wrBin <= '0;
			wrGray <= '0;
		end
		else if (pushOk)
		begin
			wrBin <= wrBinNext;
			wrGray <= wrBinNext ^ (wrBinNext >> 1);
		end
	end

	// read pointer into srcClk, two flops
	always_ff @(posedge srcClk)
	begin
		if (srcReset)
		begin
			rdGraySync1 <= '0;
			rdGraySync2 <= '0;
		end
		else
		begin
			rdGraySync1 <= rdGray;
			rdGraySync2 <= rdGraySync1;
		end
	end

	always_ff @(posedge srcClk)
	begin
		if (pushOk)
			mem[wrBin[$clog2(depth)-1:0]] <= wd;
	end

	// full when the top two gray bits differ and the rest match
	assign full = (wrGray == (rdGraySync2 ^ {2'b11, {($clog2(depth)-1){1'b0}}}));

	// --------------------------------------------------
	// destination domain
	// --------------------------------------------------

	always_ff @(posedge dstClk)
	begin
		if (dstReset)
		begin
			rdBin <= '0;
			rdGray <= '0;
		end
		else if (popOk)
		begin
			rdBin <= rdBinNext;
			rdGray <= rdBinNext ^ (rdBinNext >> 1);
		end
	end

	// write pointer into dstClk, two flops
	always_ff @(posedge dstClk)
	begin
		if (dstReset)
		begin
			wrGraySync1 <= '0;
			wrGraySync2 <= '0;
		end
		else
		begin
			wrGraySync1 <= wrGray;
			wrGraySync2 <= wrGraySync1;
		end
	end

	// data shows up one dstClk after the pop
	always_ff @(posedge dstClk)
	begin
		if (popOk)
			rd <= mem[rdBin[$clog2(depth)-1:0]];
	end

	assign empty = (rdGray == wrGraySync2);

endmodule

// ==== source/ramBridgePkg.sv ====
package ramBridgePkg;

	// --------------------------------------------------
	// widths and depths
	// --------------------------------------------------

	// byte-wide data path
	localparam int ramDqWidth = 8;

	// 1024-entry on-chip array
	localparam int ramAdrsWidth = 10;
	localparam int ramDepth = 1 << ramAdrsWidth;

	// transaction tag carried with every request
	localparam int ufiIdWidth = 3;

	// both clock-crossing FIFOs
	localparam int dualClkFifoDepth = 16;

	// pending read IDs, sized well past the outstanding reads the pipe can hold
	localparam int idFifoDepth = dualClkFifoDepth * 4;

	// --------------------------------------------------
	// request and response types
	// --------------------------------------------------

	// read is the high value
	typedef enum logic [0:0]
	{
		opWrite = 1'b0,
		opRead = 1'b1
	} memOp_t;

	// 22 bits, cmd in the msb
	typedef struct packed
	{
		memOp_t cmd;
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0] wd;
		logic [ufiIdWidth-1:0] id;
	} memReq_t;

	// 11 bits, read data and its tag
	typedef struct packed
	{
		logic [ramDqWidth-1:0] rd;
		logic [ufiIdWidth-1:0] id;
	} memRsp_t;

endpackage

// ==== source/ramClockBridge.sv ====
`timescale 1ns/1ns

module ramClockBridge (
	input logic sysClk,
	input logic memClk,
	input logic reset,
	output logic memReset,
	// requester side, sysClk
	input ramBridgePkg::memReq_t req,
	input logic reqPush,
	output logic reqFull,
	output ramBridgePkg::memRsp_t rsp,
	output logic rspValid,
	input logic rspReady,
	// controller side, memClk
	output ramBridgePkg::memReq_t memReq,
	output logic memReqEmpty,
	input logic memReqPop,
	input logic [ramBridgePkg::ramDqWidth-1:0] memRd,
	input logic memRdPush,
	output logic memRdFull
);

	logic [1:0] resetSync;
	logic idPush;
	logic rspPop;
	logic rdEmpty;

	// --------------------------------------------------
	// reset into memClk
	// --------------------------------------------------

	always_ff @(posedge memClk)
	begin
		resetSync <= {resetSync[0], reset};
	end

	// asserts straight away, release waits two memClk edges
	// so the mem-side pointers are cleared before sysClk leaves reset
	assign memReset = reset | resetSync[1];

	// --------------------------------------------------
	// request path, sys to mem
	// --------------------------------------------------

	// whole request struct crosses as one word
	grayAsyncFifo #(
		.width ($bits(ramBridgePkg::memReq_t)),
		.depth (ramBridgePkg::dualClkFifoDepth)
	) reqFifo (
		.wd       (req),
		.push     (reqPush),
		.full     (reqFull),
		.rd       (memReq),
		.pop      (memReqPop),
		.empty    (memReqEmpty),
		.srcReset (reset),
		.dstReset (memReset),
		.srcClk   (sysClk),
		.dstClk   (memClk)
	);

	// only accepted reads leave a tag behind
	assign idPush = reqPush & ~reqFull & (req.cmd == ramBridgePkg::opRead);

	// --------------------------------------------------
	// response path, mem to sys
	// --------------------------------------------------

	grayAsyncFifo #(
		.width (ramBridgePkg::ramDqWidth),
		.depth (ramBridgePkg::dualClkFifoDepth)
	) rdFifo (
		.wd       (memRd),
		.push     (memRdPush),
		.full     (memRdFull),
		.rd       (rsp.rd),
		.pop      (rspPop),
		.empty    (rdEmpty),
		.srcReset (memReset),
		.dstReset (reset),
		.srcClk   (memClk),
		.dstClk   (sysClk)
	);

	// read data and its tag pop in lockstep
	assign rspPop = rspReady & ~rdEmpty;

	// tags in issue order, never fuller than the reads in flight
	syncFifo #(
		.width (ramBridgePkg::ufiIdWidth),
		.depth (ramBridgePkg::idFifoDepth)
	) idFifo (
		.wd     (req.id),
		.push   (idPush),
		.full   (),
		.rd     (rsp.id),
		.pop    (rspPop),
		.empty  (),
		.reset  (reset),
		.sysClk (sysClk)
	);

	// both fifos register their data, so valid trails the pop by one
	always_ff @(posedge sysClk)
	begin
		if (reset)
			rspValid <= 1'b0;
		else
			rspValid <= rspPop;
	end

endmodule

// ==== source/ramSubsystem.sv ====
`timescale 1ns/1ns

module ramSubsystem (
	input logic sysClk,
	input logic memClk,
	input logic reset,
	input ramBridgePkg::memReq_t req,
	input logic reqPush,
	output logic reqFull,
	output ramBridgePkg::memRsp_t rsp,
	output logic rspValid,
	input logic rspReady
);

	// memClk side wiring
	logic memReset;
	ramBridgePkg::memReq_t memReq;
	logic memReqEmpty;
	logic memReqPop;
	logic [ramBridgePkg::ramDqWidth-1:0] memRd;
	logic memRdPush;
	logic memRdFull;

	ramClockBridge u_bridge (
		.sysClk      (sysClk),
		.memClk      (memClk),
		.reset       (reset),
		.memReset    (memReset),
		.req         (req),
		.reqPush     (reqPush),
		.reqFull     (reqFull),
		.rsp         (rsp),
		.rspValid    (rspValid),
		.rspReady    (rspReady),
		.memReq      (memReq),
		.memReqEmpty (memReqEmpty),
		.memReqPop   (memReqPop),
		.memRd       (memRd),
		.memRdPush   (memRdPush),
		.memRdFull   (memRdFull)
	);

	sramController u_ctl (
		.memClk      (memClk),
		.memReset    (memReset),
		.memReq      (memReq),
		.memReqEmpty (memReqEmpty),
		.memReqPop   (memReqPop),
		.memRd       (memRd),
		.memRdPush   (memRdPush),
		.memRdFull   (memRdFull)
	);

endmodule

// ==== source/sramController.sv ====
`timescale 1ns/1ns

module sramController (
	input logic memClk,
	input logic memReset,
	input ramBridgePkg::memReq_t memReq,
	input logic memReqEmpty,
	output logic memReqPop,
	output logic [ramBridgePkg::ramDqWidth-1:0] memRd,
	output logic memRdPush,
	input logic memRdFull
);

	typedef enum logic [1:0]
	{
		ctlIdle,
		ctlFetch,
		ctlAccess,
		ctlReturn
	} ctlState_t;

	ctlState_t state;
	ctlState_t stateNext;
	// request held for the access
	ramBridgePkg::memReq_t curReq;

	logic [ramBridgePkg::ramDqWidth-1:0] ram [ramBridgePkg::ramDepth];

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge memClk)
	begin
		if (memReset)
			state <= ctlIdle;
		else
			state <= stateNext;
	end

	always_comb
	begin
		memReqPop = 1'b0;
		memRdPush = 1'b0;
		stateNext = state;
		case (state)
			// pop as soon as something is queued
			ctlIdle:
			begin
				if (!memReqEmpty)
				begin
					memReqPop = 1'b1;
					stateNext = ctlFetch;
				end
			end
			// fifo output is valid now
			ctlFetch:
				stateNext = ctlAccess;
			// writes finish here, reads go on to return
			ctlAccess:
			begin
				if (curReq.cmd == ramBridgePkg::opRead)
					stateNext = ctlReturn;
				else
					stateNext = ctlIdle;
			end
			// stall here while the return fifo is full
			ctlReturn:
			begin
				if (!memRdFull)
				begin
					memRdPush = 1'b1;
					stateNext = ctlIdle;
				end
			end
			default:
				stateNext = ctlIdle;
		endcase
	end

	// --------------------------------------------------
	// datapath and array
	// --------------------------------------------------

	always_ff @(posedge memClk)
	begin
		if (state == ctlFetch)
			curReq <= memReq;
		if (state == ctlAccess)
		begin
			if (curReq.cmd == ramBridgePkg::opWrite)
				ram[curReq.adrs] <= curReq.wd;
			else
				memRd <= ram[curReq.adrs];
		end
	end

endmodule

// ==== source/syncFifo.sv ====
`timescale 1ns/1ns

module syncFifo #(
	parameter int width = 3,
	parameter int depth = 64
)(
	input logic [width-1:0] wd,
	input logic push,
	output logic full,
	output logic [width-1:0] rd,
	input logic pop,
	output logic empty,
	input logic reset,
	input logic sysClk
);

	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth)-1:0] rdPtr;
	// occupancy, one bit wider than the index
	logic [$clog2(depth):0] count;
	logic pushOk;
	logic popOk;

	assign pushOk = push & ~full;
	assign popOk = pop & ~empty;

	assign full = (count == ($clog2(depth)+1)'(depth));
	assign empty = (count == '0);

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (pushOk)
				wrPtr <= wrPtr + 1'b1;
			if (popOk)
				rdPtr <= rdPtr + 1'b1;
			// simultaneous push and pop leaves count alone
			case ({pushOk, popOk})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and registered read port
	always_ff @(posedge sysClk)
	begin
		if (pushOk)
			mem[wrPtr] <= wd;
		if (popOk)
			rd <= mem[rdPtr];
	end

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ns

module clockGen #(
	parameter int halfPeriod = 5
)(
	output logic clk
);

	// free-running, starts low
	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

endmodule

// ==== tb/ramChecker.sv ====
`timescale 1ns/1ns

module ramChecker (
	input logic sysClk,
	input logic reset,
	input ramBridgePkg::memReq_t req,
	input logic reqPush,
	input logic reqFull,
	input ramBridgePkg::memRsp_t rsp,
	input logic rspValid,
	output int errorCount,
	output int pending,
	output int rspCount
);

	// shadow of the ram contents
	logic [ramBridgePkg::ramDqWidth-1:0] model [ramBridgePkg::ramDepth];
	// responses still owed, in issue order
	ramBridgePkg::memRsp_t expQ [$];
	ramBridgePkg::memRsp_t want;
	int errCnt = 0;
	int pendCnt = 0;
	int rspSeen = 0;

	assign errorCount = errCnt;
	assign pending = pendCnt;
	assign rspCount = rspSeen;

	// last byte written there, tagged with the read's id
	function automatic ramBridgePkg::memRsp_t expectedRead(
		input logic [ramBridgePkg::ramAdrsWidth-1:0] adrs,
		input logic [ramBridgePkg::ufiIdWidth-1:0] id
	);
		ramBridgePkg::memRsp_t r;
		r.rd = model[adrs];
		r.id = id;
		return r;
	endfunction

	// --------------------------------------------------
	// request monitor
	// --------------------------------------------------

	// negedge sampling, everything here settles after the rising edge
	always @(negedge sysClk)
	begin
		if (!reset && reqPush === 1'b1 && reqFull === 1'b0)
		begin
			if (req.cmd == ramBridgePkg::opWrite)
				model[req.adrs] = req.wd;
			else
			begin
				expQ.push_back(expectedRead(req.adrs, req.id));
				pendCnt = expQ.size();
			end
		end
	end

	// --------------------------------------------------
	// response compare
	// --------------------------------------------------

	always @(negedge sysClk)
	begin
		if (!reset && rspValid === 1'b1)
		begin
			rspSeen++;
			if (expQ.size() == 0)
			begin
				$display("a response arrived at time %0t with no read waiting for it", $time);
				errCnt++;
			end
			else
			begin
				want = expQ.pop_front();
				// !== so that x data is caught too
				if (rsp !== want)
				begin
					$display("FAILED at time %0t: expected rd %02h id %0d, saw rd %02h id %0d",
						$time, want.rd, want.id, rsp.rd, rsp.id);
					errCnt++;
				end
			end
			pendCnt = expQ.size();
		end
	end

endmodule

// ==== tb/ramSubsystemTb.sv ====
`timescale 1ns/1ns

module ramSubsystemTb;

	// cycles allowed for any single wait
	localparam int waitLimit = 2000;

	logic sysClk;
	logic memClk;
	logic reset;
	ramBridgePkg::memReq_t req;
	logic reqPush;
	logic reqFull;
	ramBridgePkg::memRsp_t rsp;
	logic rspValid;
	logic rspReady;
	int errorCount;
	int pending;
	int rspCount;
	integer seed = 32'h7e10;
	int tbErrors = 0;
	int passCount = 0;
	int failCount = 0;
	int errorsAtStart = 0;
	int rspBefore;
	int n;
	bit randomReady = 1'b0;
	// addresses that hold known data
	logic [ramBridgePkg::ramAdrsWidth-1:0] written [$];

	clockGen #(.halfPeriod(5)) sysClkGen (.clk(sysClk));
	clockGen #(.halfPeriod(7)) memClkGen (.clk(memClk));

	ramSubsystem u_ramSubsystem (
		.sysClk   (sysClk),
		.memClk   (memClk),
		.reset    (reset),
		.req      (req),
		.reqPush  (reqPush),
		.reqFull  (reqFull),
		.rsp      (rsp),
		.rspValid (rspValid),
		.rspReady (rspReady)
	);

	ramChecker u_checker (
		.sysClk     (sysClk),
		.reset      (reset),
		.req        (req),
		.reqPush    (reqPush),
		.reqFull    (reqFull),
		.rsp        (rsp),
		.rspValid   (rspValid),
		.errorCount (errorCount),
		.pending    (pending),
		.rspCount   (rspCount)
	);

	// --------------------------------------------------
	// stimulus tasks
	// --------------------------------------------------

	// one cycle, inputs change 1 ns after the edge
	task automatic stepCycle;
		@(posedge sysClk);
		#1;
		if (randomReady)
			rspReady = 1'($random(seed));
	endtask

	task automatic pushReq(
		input ramBridgePkg::memOp_t cmd,
		input logic [ramBridgePkg::ramAdrsWidth-1:0] adrs,
		input logic [ramBridgePkg::ramDqWidth-1:0] wd
	);
		int cnt;
		cnt = 0;
		while (reqFull !== 1'b0 && cnt < waitLimit)
		begin
			stepCycle();
			cnt++;
		end
		if (reqFull !== 1'b0)
		begin
			$display("gave up waiting for reqFull to fall at time %0t", $time);
			tbErrors++;
		end
		else
		begin
			req.cmd = cmd;
			req.adrs = adrs;
			req.wd = wd;
			req.id = 3'($random(seed));
			reqPush = 1'b1;
			stepCycle();
			reqPush = 1'b0;
		end
	endtask

	task automatic writeRandom;
		logic [ramBridgePkg::ramAdrsWidth-1:0] adrs;
		adrs = 10'($random(seed));
		pushReq(ramBridgePkg::opWrite, adrs, 8'($random(seed)));
		written.push_back(adrs);
	endtask

	// reads only ever target known addresses
	task automatic readWritten;
		int idx;
		idx = $unsigned($random(seed)) % written.size();
		pushReq(ramBridgePkg::opRead, written[idx], 8'h00);
	endtask

	task automatic waitDrain;
		int cnt;
		cnt = 0;
		randomReady = 1'b0;
		rspReady = 1'b1;
		while (pending != 0 && cnt < waitLimit)
		begin
			stepCycle();
			cnt++;
		end
		if (pending != 0)
		begin
			$display("gave up waiting for %0d responses to come back", pending);
			tbErrors++;
		end
	endtask

	task automatic finishTest(input string name);
		int errs;
		errs = errorCount + tbErrors - errorsAtStart;
		if (errs == 0)
		begin
			passCount++;
			$display("test %s: pass", name);
		end
		else
		begin
			failCount++;
			$display("test %s: fail with %0d errors", name, errs);
		end
		errorsAtStart = errorCount + tbErrors;
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial
	begin
		req = '0;
		reqPush = 1'b0;
		rspReady = 1'b1;
		reset = 1'b1;
		repeat (3)
			@(posedge sysClk);
		#1;
		reset = 1'b0;

		// quiet bus, nothing should move
		repeat (20)
		begin
			stepCycle();
			if (reqFull !== 1'b0 || rspValid !== 1'b0)
			begin
				$display("reqFull or rspValid not low after reset at time %0t", $time);
				tbErrors++;
			end
		end
		finishTest("idle after reset");

		rspBefore = rspCount;
		pushReq(ramBridgePkg::opWrite, 10'h155, 8'ha7);
		pushReq(ramBridgePkg::opRead, 10'h155, 8'h00);
		written.push_back(10'h155);
		waitDrain();
		if (rspCount != rspBefore + 1)
		begin
			$display("the single read did not return exactly one response");
			tbErrors++;
		end
		finishTest("single write then read");

		repeat (40)
			writeRandom();
		repeat (40)
			readWritten();
		waitDrain();
		finishTest("random burst");

		// each read must see the write just before it
		for (int i = 0; i < 8; i++)
		begin
			pushReq(ramBridgePkg::opWrite, 10'h2c3, 8'($random(seed)));
			pushReq(ramBridgePkg::opRead, 10'h2c3, 8'h00);
		end
		written.push_back(10'h2c3);
		waitDrain();
		finishTest("read after write");

		// hold responses back until the request side fills
		rspReady = 1'b0;
		rspBefore = rspCount;
		n = 0;
		while (reqFull !== 1'b1 && n < 100)
		begin
			readWritten();
			n++;
		end
		if (reqFull !== 1'b1)
		begin
			$display("reqFull never rose with responses held back");
			tbErrors++;
		end
		repeat (50)
			stepCycle();
		if (rspCount != rspBefore)
		begin
			$display("responses came out while rspReady was low");
			tbErrors++;
		end
		if (pending != n)
		begin
			$display("%0d reads pushed but %0d still owed", n, pending);
			tbErrors++;
		end
		waitDrain();
		finishTest("back-pressure");

		randomReady = 1'b1;
		repeat (200)
		begin
			if (written.size() == 0 || ($random(seed) & 1) != 0)
				writeRandom();
			else
				readWritten();
		end
		waitDrain();
		finishTest("mixed traffic");

		$display("%0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// overall limit on the run
	initial
	begin
		repeat (100000)
			@(posedge sysClk);
		$display("the run went on too long and was stopped");
		$display("Testbench failed");
		$finish;
	end

endmodule
